// File: Makefile
# Verilator build and run for the multi-cycle RV32I core

VERILATOR  ?= verilator
TOP        ?= rv_core_tb
RTL_TOP    ?= rv_core_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard hdl/*.sv verification/*.sv verification/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulation is the pass or fail of the run
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input  logic [rv_core_pkg::XLEN-1:0] a_i,
	input  logic [rv_core_pkg::XLEN-1:0] b_i,
	input  logic [3:0]                   op_i,
	input  logic [2:0]                   funct3_i,
	output logic [rv_core_pkg::XLEN-1:0] result_o,
	output logic                         taken_o
);

	logic       eq;
	logic       lt_s;   // signed compare
	logic       lt_u;
	logic [4:0] shamt;

	assign eq    = (a_i == b_i);
	assign lt_s  = ($signed(a_i) < $signed(b_i));
	assign lt_u  = (a_i < b_i);
	assign shamt = b_i[4:0]; // rs2 or imm, low five bits only

	// ------------------------------------------------------------
	// result
	// ------------------------------------------------------------
	always_comb begin
		case (op_i)
			rv_core_pkg::ALU_ADD:    result_o = a_i + b_i;
			rv_core_pkg::ALU_SUB:    result_o = a_i - b_i;
			rv_core_pkg::ALU_SLL:    result_o = a_i << shamt;
			rv_core_pkg::ALU_SLT:    result_o = {31'd0, lt_s};
			rv_core_pkg::ALU_SLTU:   result_o = {31'd0, lt_u};
			rv_core_pkg::ALU_XOR:    result_o = a_i ^ b_i;
			rv_core_pkg::ALU_SRL:    result_o = a_i >> shamt;
			rv_core_pkg::ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
			rv_core_pkg::ALU_OR:     result_o = a_i | b_i;
			rv_core_pkg::ALU_AND:    result_o = a_i & b_i;
			rv_core_pkg::ALU_PASS_B: result_o = b_i; // lui
			default:                 result_o = '0;
		endcase
	end

	// branch decision, second half of each pair is the negation
	always_comb begin
		case (funct3_i)
			rv_core_pkg::F3_BEQ:  taken_o = eq;
			rv_core_pkg::F3_BNE:  taken_o = ~eq;
			rv_core_pkg::F3_BLT:  taken_o = lt_s;
			rv_core_pkg::F3_BGE:  taken_o = ~lt_s;
			rv_core_pkg::F3_BLTU: taken_o = lt_u;
			rv_core_pkg::F3_BGEU: taken_o = ~lt_u;
			default:              taken_o = 1'b0;
		endcase
	end

endmodule

// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int XLEN      = 32;
	localparam int REG_COUNT = 32;
	localparam int REG_IDX_W = 5;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// funct3 for the integer ops
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101; // srl or sra, bit 30 decides
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	// branch conditions
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [2:0] F3_BLT     = 3'b100;
	localparam logic [2:0] F3_BGE     = 3'b101;
	localparam logic [2:0] F3_BLTU    = 3'b110;
	localparam logic [2:0] F3_BGEU    = 3'b111;
	localparam logic [2:0] F3_WORD    = 3'b010; // lw / sw only

	// ------------------------------------------------------------
	// internal encodings
	// ------------------------------------------------------------
	localparam logic [3:0] ALU_ADD    = 4'd0;
	localparam logic [3:0] ALU_SUB    = 4'd1;
	localparam logic [3:0] ALU_SLL    = 4'd2;
	localparam logic [3:0] ALU_SLT    = 4'd3;
	localparam logic [3:0] ALU_SLTU   = 4'd4;
	localparam logic [3:0] ALU_XOR    = 4'd5;
	localparam logic [3:0] ALU_SRL    = 4'd6;
	localparam logic [3:0] ALU_SRA    = 4'd7;
	localparam logic [3:0] ALU_OR     = 4'd8;
	localparam logic [3:0] ALU_AND    = 4'd9;
	localparam logic [3:0] ALU_PASS_B = 4'd10; // lui

	localparam logic [2:0] CLS_ALU     = 3'd0; // op, op-imm, lui, auipc
	localparam logic [2:0] CLS_LOAD    = 3'd1;
	localparam logic [2:0] CLS_STORE   = 3'd2;
	localparam logic [2:0] CLS_BRANCH  = 3'd3;
	localparam logic [2:0] CLS_JAL     = 3'd4;
	localparam logic [2:0] CLS_JALR    = 3'd5;
	localparam logic [2:0] CLS_ILLEGAL = 3'd7;

	// machine cycles
	localparam logic [2:0] MC_FETCH   = 3'd0;
	localparam logic [2:0] MC_OPERAND = 3'd1;
	localparam logic [2:0] MC_EXECUTE = 3'd2;
	localparam logic [2:0] MC_MEMWB   = 3'd3;
	localparam logic [2:0] MC_HALT    = 3'd4;

	// one instruction word, six ways to read it
	typedef union packed {
		struct packed {
			logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm_11_0; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
		} i;
		struct packed {
			logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
		} s;
		struct packed {
			logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
		} u;
		struct packed {
			logic imm_20; logic [9:0] imm_10_1; logic imm_11;
			logic [7:0] imm_19_12; logic [4:0] rd; logic [6:0] opcode;
		} j;
	} inst_t;

endpackage

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
	parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0,
	parameter logic [rv_core_pkg::XLEN-1:0] SP_RESET = 32'h0000_1000
) (
	input  logic                           clock_i,
	input  logic                           reset_i,
	// instruction port
	output logic                           imem_req_o,
	output logic [rv_core_pkg::XLEN-1:0]   imem_addr_o,
	input  logic [rv_core_pkg::XLEN-1:0]   imem_rdata_i,
	input  logic                           imem_done_i,
	// data port
	output logic                           dmem_req_o,
	output logic                           dmem_we_o,
	output logic [rv_core_pkg::XLEN-1:0]   dmem_addr_o,
	output logic [rv_core_pkg::XLEN-1:0]   dmem_wdata_o,
	input  logic [rv_core_pkg::XLEN-1:0]   dmem_rdata_i,
	input  logic                           dmem_done_i,
	// trace
	output logic                           retire_o,
	output logic [rv_core_pkg::XLEN-1:0]   retire_pc_o,
	output rv_core_pkg::inst_t             retire_inst_o,
	output logic                           illegal_o
);

	rv_core_pkg::inst_t                   inst;      // ir, seen by decoder
	logic [rv_core_pkg::XLEN-1:0]         dec_imm;
	logic [rv_core_pkg::REG_IDX_W-1:0]    dec_rs1;
	logic [rv_core_pkg::REG_IDX_W-1:0]    dec_rs2;
	logic [rv_core_pkg::REG_IDX_W-1:0]    dec_rd;
	logic [3:0]                           dec_alu_op;
	logic [2:0]                           dec_class;
	logic                                 dec_use_imm;
	logic                                 dec_illegal;
	logic [rv_core_pkg::XLEN-1:0]         rf_rdata1, rf_rdata2, rf_wdata;
	logic                                 rf_we;
	logic [rv_core_pkg::REG_IDX_W-1:0]    rf_waddr;
	logic [rv_core_pkg::XLEN-1:0]         alu_a, alu_b, alu_result;
	logic [3:0]                           alu_op;
	logic                                 alu_taken;

	rv_sequencer #(.RESET_PC(RESET_PC)) i_seq (
		.clock_i, .reset_i,
		.imem_req_o, .imem_addr_o, .imem_rdata_i, .imem_done_i,
		.dmem_req_o, .dmem_we_o, .dmem_addr_o, .dmem_wdata_o, .dmem_rdata_i, .dmem_done_i,
		.retire_o, .retire_pc_o, .retire_inst_o, .illegal_o,
		.inst_o(inst),
		.dec_imm_i(dec_imm), .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2), .dec_rd_i(dec_rd),
		.dec_alu_op_i(dec_alu_op), .dec_class_i(dec_class),
		.dec_use_imm_i(dec_use_imm), .dec_illegal_i(dec_illegal),
		.rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
		.rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
		.alu_a_o(alu_a), .alu_b_o(alu_b), .alu_op_o(alu_op),
		.alu_result_i(alu_result), .alu_taken_i(alu_taken)
	);

	rv_decoder i_dec (
		.inst_i(inst), .imm_o(dec_imm), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
		.alu_op_o(dec_alu_op), .class_o(dec_class),
		.use_imm_o(dec_use_imm), .illegal_o(dec_illegal)
	);

	rv_regfile #(.SP_RESET(SP_RESET)) i_rf (
		.clock_i, .reset_i,
		.raddr1_i(dec_rs1), .raddr2_i(dec_rs2), .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2),
		.we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
	);

	// branch condition comes straight from the ir funct3
	rv_alu i_alu (
		.a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .funct3_i(inst.b.funct3),
		.result_o(alu_result), .taken_o(alu_taken)
	);

endmodule

// File: hdl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input  rv_core_pkg::inst_t                inst_i,
	output logic [rv_core_pkg::XLEN-1:0]      imm_o,
	output logic [rv_core_pkg::REG_IDX_W-1:0] rs1_o,
	output logic [rv_core_pkg::REG_IDX_W-1:0] rs2_o,
	output logic [rv_core_pkg::REG_IDX_W-1:0] rd_o,
	output logic [3:0]                        alu_op_o,
	output logic [2:0]                        class_o,
	output logic                              use_imm_o,
	output logic                              illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       alt_op;   // bit 30, sub / sra
	logic       bad_f3;

	assign opcode = inst_i.r.opcode;
	assign funct3 = inst_i.r.funct3;
	assign rs1_o  = inst_i.r.rs1;
	assign rs2_o  = inst_i.r.rs2;
	assign rd_o   = inst_i.r.rd;
	// op-imm only honours bit 30 on right shifts, addi has no subi
	assign alt_op = inst_i.r.funct7[5] & ((opcode == rv_core_pkg::OPC_OP) | (funct3 == rv_core_pkg::F3_SR));

	// immediate format by opcode
	always_comb begin
		case (opcode)
			rv_core_pkg::OPC_STORE:
				imm_o = {{20{inst_i.s.imm_11_5[6]}}, inst_i.s.imm_11_5, inst_i.s.imm_4_0};
			rv_core_pkg::OPC_BRANCH:
				imm_o = {{19{inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
					inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
			rv_core_pkg::OPC_LUI, rv_core_pkg::OPC_AUIPC:
				imm_o = {inst_i.u.imm_31_12, 12'h000};
			rv_core_pkg::OPC_JAL:
				imm_o = {{11{inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
					inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};
			default: imm_o = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0}; // i-type
		endcase
	end

	always_comb begin
		alu_op_o  = rv_core_pkg::ALU_ADD; // address and target adds
		use_imm_o = 1'b1;
		class_o   = rv_core_pkg::CLS_ILLEGAL;
		bad_f3    = 1'b0;
		case (opcode)
			rv_core_pkg::OPC_OP, rv_core_pkg::OPC_OP_IMM: begin
				class_o   = rv_core_pkg::CLS_ALU;
				use_imm_o = (opcode == rv_core_pkg::OPC_OP_IMM);
				case (funct3)
					rv_core_pkg::F3_ADD_SUB: alu_op_o = alt_op ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
					rv_core_pkg::F3_SLL:     alu_op_o = rv_core_pkg::ALU_SLL;
					rv_core_pkg::F3_SLT:     alu_op_o = rv_core_pkg::ALU_SLT;
					rv_core_pkg::F3_SLTU:    alu_op_o = rv_core_pkg::ALU_SLTU;
					rv_core_pkg::F3_XOR:     alu_op_o = rv_core_pkg::ALU_XOR;
					rv_core_pkg::F3_SR:      alu_op_o = alt_op ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
					rv_core_pkg::F3_OR:      alu_op_o = rv_core_pkg::ALU_OR;
					default:                 alu_op_o = rv_core_pkg::ALU_AND;
				endcase
			end
			rv_core_pkg::OPC_LUI: begin
				class_o  = rv_core_pkg::CLS_ALU;
				alu_op_o = rv_core_pkg::ALU_PASS_B;
			end
			rv_core_pkg::OPC_AUIPC: class_o = rv_core_pkg::CLS_ALU; // pc + imm
			rv_core_pkg::OPC_LOAD: begin
				class_o = rv_core_pkg::CLS_LOAD;
				bad_f3  = (funct3 != rv_core_pkg::F3_WORD); // words only
			end
			rv_core_pkg::OPC_STORE: begin
				class_o = rv_core_pkg::CLS_STORE;
				bad_f3  = (funct3 != rv_core_pkg::F3_WORD);
			end
			rv_core_pkg::OPC_BRANCH: begin
				class_o   = rv_core_pkg::CLS_BRANCH;
				use_imm_o = 1'b0; // rs1 against rs2
				case (funct3)
					rv_core_pkg::F3_BEQ, rv_core_pkg::F3_BNE:   alu_op_o = rv_core_pkg::ALU_SUB;
					rv_core_pkg::F3_BLT, rv_core_pkg::F3_BGE:   alu_op_o = rv_core_pkg::ALU_SLT;
					rv_core_pkg::F3_BLTU, rv_core_pkg::F3_BGEU: alu_op_o = rv_core_pkg::ALU_SLTU;
					default:                                    bad_f3 = 1'b1;
				endcase
			end
			rv_core_pkg::OPC_JAL:  class_o = rv_core_pkg::CLS_JAL;
			rv_core_pkg::OPC_JALR: class_o = rv_core_pkg::CLS_JALR;
			default: ; // unknown opcode stays illegal
		endcase
		illegal_o = bad_f3 | (class_o == rv_core_pkg::CLS_ILLEGAL);
		if (bad_f3)
			class_o = rv_core_pkg::CLS_ILLEGAL;
	end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile #(
	parameter logic [rv_core_pkg::XLEN-1:0] SP_RESET = 32'h0000_1000
) (
	input  logic                              clock_i,
	input  logic                              reset_i,
	input  logic [rv_core_pkg::REG_IDX_W-1:0] raddr1_i,
	input  logic [rv_core_pkg::REG_IDX_W-1:0] raddr2_i,
	output logic [rv_core_pkg::XLEN-1:0]      rdata1_o,
	output logic [rv_core_pkg::XLEN-1:0]      rdata2_o,
	input  logic                              we_i,
	input  logic [rv_core_pkg::REG_IDX_W-1:0] waddr_i,
	input  logic [rv_core_pkg::XLEN-1:0]      wdata_i
);

	logic [rv_core_pkg::XLEN-1:0] regs [rv_core_pkg::REG_COUNT];

	// two async read ports, writes show up next cycle
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			for (int k = 0; k < rv_core_pkg::REG_COUNT; k++)
				regs[k] <= (k == 2) ? SP_RESET : '0; // x2 is sp
		end else if (we_i && (waddr_i != '0)) begin // x0 never written
			regs[waddr_i] <= wdata_i;
		end
	end

endmodule

// File: hdl/rv_sequencer.sv
`timescale 1ns/1ps

module rv_sequencer #(
	parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                              clock_i,
	input  logic                              reset_i,
	output logic                              imem_req_o,
	output logic [rv_core_pkg::XLEN-1:0]      imem_addr_o,
	input  logic [rv_core_pkg::XLEN-1:0]      imem_rdata_i,
	input  logic                              imem_done_i,
	output logic                              dmem_req_o,
	output logic                              dmem_we_o,
	output logic [rv_core_pkg::XLEN-1:0]      dmem_addr_o,
	output logic [rv_core_pkg::XLEN-1:0]      dmem_wdata_o,
	input  logic [rv_core_pkg::XLEN-1:0]      dmem_rdata_i,
	input  logic                              dmem_done_i,
	output logic                              retire_o,
	output logic [rv_core_pkg::XLEN-1:0]      retire_pc_o,
	output rv_core_pkg::inst_t                retire_inst_o,
	output logic                              illegal_o,
	output rv_core_pkg::inst_t                inst_o,
	input  logic [rv_core_pkg::XLEN-1:0]      dec_imm_i,
	input  logic [rv_core_pkg::REG_IDX_W-1:0] dec_rs1_i,
	input  logic [rv_core_pkg::REG_IDX_W-1:0] dec_rs2_i,
	input  logic [rv_core_pkg::REG_IDX_W-1:0] dec_rd_i,
	input  logic [3:0]                        dec_alu_op_i,
	input  logic [2:0]                        dec_class_i,
	input  logic                              dec_use_imm_i,
	input  logic                              dec_illegal_i,
	input  logic [rv_core_pkg::XLEN-1:0]      rf_rdata1_i,
	input  logic [rv_core_pkg::XLEN-1:0]      rf_rdata2_i,
	output logic                              rf_we_o,
	output logic [rv_core_pkg::REG_IDX_W-1:0] rf_waddr_o,
	output logic [rv_core_pkg::XLEN-1:0]      rf_wdata_o,
	output logic [rv_core_pkg::XLEN-1:0]      alu_a_o,
	output logic [rv_core_pkg::XLEN-1:0]      alu_b_o,
	output logic [3:0]                        alu_op_o,
	input  logic [rv_core_pkg::XLEN-1:0]      alu_result_i,
	input  logic                              alu_taken_i
);

	logic [2:0]                   state;
	logic                         boot_q;         // first fetch after reset still owed
	logic [rv_core_pkg::XLEN-1:0] pc, npc;        // pc of current inst, pc of next
	rv_core_pkg::inst_t           ir;
	logic [rv_core_pkg::XLEN-1:0] op_a, op_b;     // operand registers
	logic [rv_core_pkg::XLEN-1:0] result;         // value for rd
	logic [rv_core_pkg::XLEN-1:0] pc_plus4, pc_target, next_pc;
	logic                         is_mem, wb_fire;

	assign inst_o   = ir;
	assign alu_a_o  = op_a;
	assign alu_b_o  = op_b;
	assign alu_op_o = dec_alu_op_i; // ir is stable, so decode holds all through execute

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + dec_imm_i; // branch and jal, relative to this inst

	always_comb begin
		case (dec_class_i)
			rv_core_pkg::CLS_BRANCH: next_pc = alu_taken_i ? pc_target : pc_plus4;
			rv_core_pkg::CLS_JAL:    next_pc = pc_target;
			rv_core_pkg::CLS_JALR:   next_pc = {alu_result_i[rv_core_pkg::XLEN-1:1], 1'b0};
			default:                 next_pc = pc_plus4;
		endcase
	end

	// ------------------------------------------------------------
	// writeback
	// ------------------------------------------------------------
	assign is_mem  = (dec_class_i == rv_core_pkg::CLS_LOAD) | (dec_class_i == rv_core_pkg::CLS_STORE);
	assign wb_fire = (state == rv_core_pkg::MC_MEMWB) & (~is_mem | dmem_done_i);

	// stores and branches have no rd, x0 writes are dropped in the regfile
	assign rf_we_o    = wb_fire & (dec_class_i != rv_core_pkg::CLS_STORE)
		& (dec_class_i != rv_core_pkg::CLS_BRANCH);
	assign rf_waddr_o = dec_rd_i;
	assign rf_wdata_o = (dec_class_i == rv_core_pkg::CLS_LOAD) ? dmem_rdata_i : result;

	// ------------------------------------------------------------
	// machine cycles
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			state      <= rv_core_pkg::MC_FETCH;
			boot_q     <= 1'b1;
			pc         <= RESET_PC;
			imem_req_o <= 1'b0;
			dmem_req_o <= 1'b0;
			dmem_we_o  <= 1'b0;
			retire_o   <= 1'b0;
			illegal_o  <= 1'b0;
		end else begin
			imem_req_o <= 1'b0; // all requests are single-cycle pulses
			dmem_req_o <= 1'b0;
			dmem_we_o  <= 1'b0;
			retire_o   <= 1'b0;
			case (state)
				rv_core_pkg::MC_FETCH: begin
					if (boot_q) begin
						boot_q      <= 1'b0;
						imem_req_o  <= 1'b1;
						imem_addr_o <= pc;
					end else if (imem_done_i) begin // otherwise hold
						ir    <= imem_rdata_i;
						state <= rv_core_pkg::MC_OPERAND;
					end
				end
				rv_core_pkg::MC_OPERAND: begin
					if (dec_illegal_i) begin
						illegal_o <= 1'b1; // sticky until reset
						state     <= rv_core_pkg::MC_HALT;
					end else begin
						// auipc adds to its own pc, x0 sources short to zero
						if (ir.u.opcode == rv_core_pkg::OPC_AUIPC)
							op_a <= pc;
						else
							op_a <= (dec_rs1_i == '0) ? '0 : rf_rdata1_i;
						if (dec_use_imm_i)
							op_b <= dec_imm_i;
						else
							op_b <= (dec_rs2_i == '0) ? '0 : rf_rdata2_i;
						state <= rv_core_pkg::MC_EXECUTE;
					end
				end
				rv_core_pkg::MC_EXECUTE: begin
					npc <= next_pc;
					// jumps link the return address, everything else takes the alu
					if ((dec_class_i == rv_core_pkg::CLS_JAL) | (dec_class_i == rv_core_pkg::CLS_JALR))
						result <= pc_plus4;
					else
						result <= alu_result_i;
					if (is_mem) begin
						dmem_req_o   <= 1'b1;
						dmem_we_o    <= (dec_class_i == rv_core_pkg::CLS_STORE);
						dmem_addr_o  <= alu_result_i; // rs1 + offset
						dmem_wdata_o <= rf_rdata2_i;
					end
					state <= rv_core_pkg::MC_MEMWB;
				end
				rv_core_pkg::MC_MEMWB: begin
					if (wb_fire) begin
						retire_o      <= 1'b1;
						retire_pc_o   <= pc;
						retire_inst_o <= ir;
						pc            <= npc;
						imem_req_o    <= 1'b1; // next fetch alongside the retire pulse
						imem_addr_o   <= npc;
						state         <= rv_core_pkg::MC_FETCH;
					end
				end
				default: state <= rv_core_pkg::MC_HALT; // halt, only reset leaves
			endcase
		end
	end

endmodule

// File: sources.f
+incdir+verification
hdl/rv_core_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_sequencer.sv
hdl/rv_core_top.sv
verification/rv_core_tb.sv

// File: verification/rv_iss_model.svh
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

	// ------------------------------------------------------------
	// architectural reference, runs the whole program up front
	// ------------------------------------------------------------

	// word slot of a data address, window starts at SP_RESET
	function automatic int data_index(input logic [XLEN-1:0] addr);
		return int'((addr - SP_RESET) >> 2);
	endfunction

	// integer ops as the ISA defines them, alt is instruction bit 30
	function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'd0, $signed(a) < $signed(b)};
			3'd3:    return {31'd0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			default: return a >= b; // bgeu
		endcase
	endfunction

	task automatic run_model();
		logic [XLEN-1:0] w, pc, nxt, a, b, res, addr;
		logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
		logic            wr, halted;
		for (int r = 0; r < 32; r++)
			mdl_x[r] = '0;
		mdl_x[2] = SP_RESET; // sp
		pc     = RESET_PC;
		halted = 1'b0;
		while (!halted) begin
			w     = imem[pc[9:2]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			a     = mdl_x[w[19:15]];
			b     = mdl_x[w[24:20]];
			nxt   = pc + 32'd4;
			res   = pc + 32'd4;  // link value for both jumps
			wr    = 1'b1;
			exp_fetch.push_back(pc);
			case (w[6:0])
				rv_core_pkg::OPC_OP:     res = alu_ref(w[14:12], w[30], a, b);
				rv_core_pkg::OPC_OP_IMM: res = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm_i);
				rv_core_pkg::OPC_LUI:    res = {w[31:12], 12'h000};
				rv_core_pkg::OPC_AUIPC:  res = pc + {w[31:12], 12'h000};
				rv_core_pkg::OPC_JAL:    nxt = pc + imm_j;
				rv_core_pkg::OPC_JALR:   nxt = (a + imm_i) & ~32'd1;
				rv_core_pkg::OPC_BRANCH: begin
					wr = 1'b0;
					if (branch_ref(w[14:12], a, b))
						nxt = pc + imm_b;
				end
				rv_core_pkg::OPC_LOAD: begin
					addr = a + imm_i;
					res  = dmem[data_index(addr)];
					exp_daddr.push_back(addr);
					exp_we.push_back(1'b0);
					exp_wdata.push_back('0);
				end
				rv_core_pkg::OPC_STORE: begin
					wr   = 1'b0;
					addr = a + imm_s;
					dmem[data_index(addr)] = b;
					exp_daddr.push_back(addr);
					exp_we.push_back(1'b1);
					exp_wdata.push_back(b);
				end
				default: halted = 1'b1; // illegal word, fetched but never retired
			endcase
			if (!halted) begin
				exp_inst.push_back(w);
				if (wr && (w[11:7] != 5'd0))
					mdl_x[w[11:7]] = res;
				pc = nxt;
			end
		end
	endtask

`endif

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

	localparam int XLEN       = rv_core_pkg::XLEN;
	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam logic [31:0] SP_RESET = 32'h0000_1000;
	localparam int N_RAND     = 120;            // random part of the program
	localparam int PROG_LEN   = N_RAND + 33;    // + store burst + illegal word
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 64;             // window at SP_RESET with the burst in the upper half
	localparam int MAX_LAT    = 4;
	localparam int WATCHDOG_CYCLES = PROG_LEN * 4 * (MAX_LAT + 1) * 2;

	logic               clock;
	logic               reset_n;
	logic               imem_req, dmem_req, dmem_we, retire, illegal;
	logic [XLEN-1:0]    imem_addr, dmem_addr, dmem_wdata, retire_pc;
	rv_core_pkg::inst_t retire_inst;
	logic               imem_done  = 1'b0;
	logic               dmem_done  = 1'b0;
	logic [XLEN-1:0]    imem_rdata = '0;
	logic [XLEN-1:0]    dmem_rdata = '0;

	logic [XLEN-1:0]    imem [IMEM_WORDS];
	logic [XLEN-1:0]    dmem [DMEM_WORDS];  // shared by model and data responder
	logic [XLEN-1:0]    mdl_x [32];         // model register file
	logic [XLEN-1:0]    exp_fetch[$], exp_daddr[$], exp_wdata[$];
	logic               exp_we[$];
	rv_core_pkg::inst_t exp_inst[$];

	integer          seed;
	int              fetch_idx  = 0;
	int              retire_idx = 0;
	int              dmem_idx   = 0;
	int              imem_cnt   = 0;
	int              dmem_cnt   = 0;
	logic            imem_busy  = 1'b0;   // done still owed on the port
	logic            dmem_busy  = 1'b0;
	logic [XLEN-1:0] load_hold  = '0;

	`include "rv_iss_model.svh"

	rv_core_top #(.RESET_PC(RESET_PC), .SP_RESET(SP_RESET)) i_dut (
		.clock_i(clock), .reset_i(reset_n),
		.imem_req_o(imem_req), .imem_addr_o(imem_addr),
		.imem_rdata_i(imem_rdata), .imem_done_i(imem_done),
		.dmem_req_o(dmem_req), .dmem_we_o(dmem_we), .dmem_addr_o(dmem_addr),
		.dmem_wdata_o(dmem_wdata), .dmem_rdata_i(dmem_rdata), .dmem_done_i(dmem_done),
		.retire_o(retire), .retire_pc_o(retire_pc), .retire_inst_o(retire_inst),
		.illegal_o(illegal)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_inst(input string name, input rv_core_pkg::inst_t got,
		input rv_core_pkg::inst_t exp);
		if (got !== exp)
			stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	// ------------------------------------------------------------
	// program and data image
	// ------------------------------------------------------------
	function automatic logic [4:0] pick_dest_reg();
		logic [4:0] r;
		r = 5'($random(seed));
		return (r == 5'd2) ? 5'd0 : r; // sp stays the data base
	endfunction

	task automatic fill_data();
		logic [XLEN-1:0] addr;
		for (int k = 0; k < DMEM_WORDS; k++) begin
			addr    = SP_RESET + 32'(4 * k);
			dmem[k] = (addr * 32'h9e37_79b1) ^ 32'hc3c3_0000;
		end
	endtask

	task automatic build_program();
		int          i, kind, skip;
		logic [31:0] rnd, w;
		logic [4:0]  rd, rs1, rs2, rt;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		logic [12:0] off;
		logic [20:0] joff;
		bit          landing [N_RAND];   // word that a forward jump lands on
		for (int k = 0; k < IMEM_WORDS; k++)
			imem[k] = 32'((4 * k) << 7); // opcode 0 is illegal wherever unused
		i = 0;
		while (i < N_RAND) begin
			rnd  = $random(seed);
			kind = {$random(seed)} % 10;
			skip = 1 + ({$random(seed)} % 3);
			rd   = pick_dest_reg();
			rt   = pick_dest_reg();
			rs1  = rnd[19:15];
			rs2  = rnd[24:20];
			f3   = rnd[14:12];
			if (i + 3 + skip > N_RAND)
				kind = 0; // no jump may land past the burst
			if ((kind == 8) && landing[i + 1])
				kind = 0; // jumped-over auipc would leave a stale base
			case (kind)
				0, 1, 2: begin
					f7 = (((f3 == 3'd0) || (f3 == 3'd5)) && rnd[0]) ? 7'h20 : 7'h00;
					w  = {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
				end
				3, 4: begin
					imm = rnd[31:20];
					if ((f3 == 3'd1) || (f3 == 3'd5)) // shifts keep a legal funct7
						imm = {((f3 == 3'd5) && rnd[0]) ? 7'h20 : 7'h00, rnd[24:20]};
					w = {imm, rs1, f3, rd, rv_core_pkg::OPC_OP_IMM};
				end
				5: w = {rnd[31:12], rd, rnd[0] ? rv_core_pkg::OPC_LUI : rv_core_pkg::OPC_AUIPC};
				6: begin
					if ((f3 == 3'd2) || (f3 == 3'd3))
						f3 = f3 + 3'd4; // no such branch
					off = 13'(4 * (skip + 1));
					w   = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
						rv_core_pkg::OPC_BRANCH};
					landing[i + skip + 1] = 1'b1;
				end
				7: begin
					joff = 21'(4 * (skip + 1));
					w    = {joff[20], joff[10:1], joff[11], joff[19:12], rd, rv_core_pkg::OPC_JAL};
					landing[i + skip + 1] = 1'b1;
				end
				8: begin
					// auipc rt,0 then jalr with an odd offset
					if (rt == 5'd0)
						rt = 5'd1;
					imem[i] = {20'h00000, rt, rv_core_pkg::OPC_AUIPC};
					i++;
					w = {12'(9 + 4 * skip), rt, 3'b000, rd, rv_core_pkg::OPC_JALR};
				end
				default: begin
					imm = 12'(4 * rnd[4:0]); // lower half of the window
					if (rnd[5])
						w = {imm[11:5], rs2, 5'd2, rv_core_pkg::F3_WORD, imm[4:0],
							rv_core_pkg::OPC_STORE};
					else
						w = {imm, 5'd2, rv_core_pkg::F3_WORD, rd, rv_core_pkg::OPC_LOAD};
				end
			endcase
			imem[i] = w;
			i++;
		end
		// every register to the upper half and then stop
		for (int r = 0; r < 32; r++) begin
			imm = 12'(128 + 4 * r);
			imem[N_RAND + r] = {imm[11:5], 5'(r), 5'd2, rv_core_pkg::F3_WORD, imm[4:0],
				rv_core_pkg::OPC_STORE};
		end
		imem[N_RAND + 32] = 32'h0000_0000;
	endtask

	// ------------------------------------------------------------
	// memory responders and trace monitor on the falling edge
	// ------------------------------------------------------------
	always @(negedge clock) begin
		imem_done = 1'b0;
		if (imem_req) begin
			if (imem_busy)
				stop_run("instruction request issued while the previous fetch was still open");
			if (fetch_idx >= exp_fetch.size())
				stop_run("instruction fetch after the illegal word");
			check_word("imem_addr_o", imem_addr, exp_fetch[fetch_idx]);
			fetch_idx++;
			imem_busy = 1'b1;
			imem_cnt  = 1 + ({$random(seed)} % MAX_LAT);
		end else if (imem_busy) begin
			imem_cnt--;
			if (imem_cnt == 0) begin
				imem_done  = 1'b1;
				imem_rdata = imem[imem_addr[9:2]];
				imem_busy  = 1'b0;
			end
		end
	end

	always @(negedge clock) begin
		dmem_done = 1'b0;
		if (dmem_req) begin
			if (dmem_busy)
				stop_run("data request issued while the previous access was still open");
			if (dmem_idx >= exp_daddr.size())
				stop_run("data request that the model does not make");
			check_word("dmem_addr_o", dmem_addr, exp_daddr[dmem_idx]);
			compare_flag("dmem_we_o", dmem_we, exp_we[dmem_idx]);
			if (dmem_we) begin
				check_word("dmem_wdata_o", dmem_wdata, exp_wdata[dmem_idx]);
				dmem[data_index(dmem_addr)] = dmem_wdata;
			end else begin
				load_hold = dmem[data_index(dmem_addr)];
			end
			dmem_idx++;
			dmem_busy = 1'b1;
			dmem_cnt  = 1 + ({$random(seed)} % MAX_LAT);
		end else if (dmem_busy) begin
			dmem_cnt--;
			if (dmem_cnt == 0) begin
				dmem_done  = 1'b1;
				dmem_rdata = load_hold; // don't care after a store
				dmem_busy  = 1'b0;
			end
		end
	end

	always @(negedge clock) begin
		if (retire) begin
			if (retire_idx >= exp_inst.size())
				stop_run("retire pulse after the last instruction of the program");
			check_word("retire_pc_o", retire_pc, exp_fetch[retire_idx]);
			check_inst("retire_inst_o", retire_inst, exp_inst[retire_idx]);
			retire_idx++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		stop_run("watchdog expired, the core never reached the illegal word");
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		seed    = 32'hdd462f5b;
		reset_n = 1'b0;
		build_program();
		fill_data();
		run_model();
		fill_data(); // same image for the DUT run
		repeat (2) @(posedge clock);
		@(negedge clock);
		compare_flag("imem_req_o", imem_req, 1'b0);
		compare_flag("dmem_req_o", dmem_req, 1'b0);
		compare_flag("dmem_we_o", dmem_we, 1'b0);
		compare_flag("retire_o", retire, 1'b0);
		compare_flag("illegal_o", illegal, 1'b0);
		reset_n = 1'b1;
		@(negedge clock);
		compare_flag("imem_req_o", imem_req, 1'b1); // boot fetch whose address the responder checks
		while (illegal !== 1'b1)
			@(negedge clock);
		if ((fetch_idx != exp_fetch.size()) || (retire_idx != exp_inst.size()))
			stop_run("core halted before the program ran up to the illegal word");
		if (dmem_idx != exp_daddr.size())
			stop_run("core made fewer data requests than the model");
		repeat (20) begin
			@(negedge clock);
			compare_flag("imem_req_o", imem_req, 1'b0);
			compare_flag("dmem_req_o", dmem_req, 1'b0);
			compare_flag("retire_o", retire, 1'b0);
			compare_flag("illegal_o", illegal, 1'b1); // sticky
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule
